/* cpu_core.f */
+incdir+tests
src/cpu_pkg.sv
src/fwd_if.sv
src/pipe_reg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/hazard_unit.sv
src/execute_unit.sv
src/memory_unit.sv
src/cpu_top.sv
tests/tb_cpu_top.sv

/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int ISA_WIDTH      = 32;
    localparam int REG_ADDR_WIDTH = 5;

    typedef logic [ISA_WIDTH - 1:0]      word_t;
    typedef logic [REG_ADDR_WIDTH - 1:0] reg_idx_t;

    // op [31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {           // func [5:0], r type only
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_t;   // add is 0

    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_t;   // operand source in ex

    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc_plus4;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        alu_op_t  alu_op;
        word_t    op1;                   // rs value
        word_t    op2;                   // rt value or immediate
        word_t    store_data;            // sw only
        reg_idx_t src1;                  // 0 when unused
        reg_idx_t src2;
        reg_idx_t dst;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    result;                // alu result, also memory byte address
        word_t    store_data;
        reg_idx_t dst;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dst;
        logic     reg_write;
        word_t    result;                // load data or alu result
    } mem_wb_t;

endpackage

`default_nettype wire

/* src/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,           // low: load program, pipeline flushed
    input  logic              imem_we,
    input  cpu_pkg::word_t    imem_addr,
    input  cpu_pkg::word_t    imem_wdata,
    output logic              retire_valid,  // one strobe per register write
    output cpu_pkg::reg_idx_t retire_reg,
    output cpu_pkg::word_t    retire_data
);

    cpu_pkg::if_id_t  if_d, if_q;
    cpu_pkg::id_ex_t  id_d, id_q;
    cpu_pkg::ex_mem_t ex_d, ex_q;
    cpu_pkg::mem_wb_t mem_d, mem_q;

    logic           stall_front, flush_if_id, flush_id_ex;
    logic           redirect, is_branch;
    cpu_pkg::word_t redirect_pc;

    fwd_if fwd (.clk(clk), .rst_n(rst_n));

    // wb side of the forwarding bus straight from mem/wb
    assign fwd.wb_dst    = mem_q.dst;
    assign fwd.wb_we     = mem_q.valid && mem_q.reg_write;
    assign fwd.wb_result = mem_q.result;

    assign retire_valid = mem_q.valid && mem_q.reg_write;
    assign retire_reg   = mem_q.dst;
    assign retire_data  = mem_q.result;

    fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_unit_i (
        .clk(clk), .rst_n(rst_n), .run(run),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .stall(stall_front), .redirect(redirect), .redirect_pc(redirect_pc),
        .fetched(if_d)
    );

    pipe_reg #(.payload_t(cpu_pkg::if_id_t)) if_id_reg (
        .clk(clk), .rst_n(rst_n), .stall(stall_front), .flush(flush_if_id), .d(if_d), .q(if_q)
    );

    decode_unit decode_unit_i (
        .clk(clk), .rst_n(rst_n), .in(if_q), .fwd(fwd),
        .out(id_d), .redirect(redirect), .redirect_pc(redirect_pc), .is_branch(is_branch)
    );

    hazard_unit hazard_unit_i (
        .id_src1(id_d.src1), .id_src2(id_d.src2), .is_branch(is_branch),
        .ex_stage(id_q), .fwd(fwd), .redirect(redirect), .run(run),
        .stall_front(stall_front), .flush_if_id(flush_if_id), .flush_id_ex(flush_id_ex)
    );

    pipe_reg #(.payload_t(cpu_pkg::id_ex_t)) id_ex_reg (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(flush_id_ex), .d(id_d), .q(id_q)
    );

    execute_unit execute_unit_i (.in(id_q), .fwd(fwd), .out(ex_d));

    pipe_reg #(.payload_t(cpu_pkg::ex_mem_t)) ex_mem_reg (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(!run), .d(ex_d), .q(ex_q)
    );

    memory_unit #(.DMEM_DEPTH(DMEM_DEPTH)) memory_unit_i (
        .clk(clk), .rst_n(rst_n), .in(ex_q), .out(mem_d), .fwd(fwd)
    );

    pipe_reg #(.payload_t(cpu_pkg::mem_wb_t)) mem_wb_reg (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(!run), .d(mem_d), .q(mem_q)
    );

endmodule

`default_nettype wire

/* src/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  cpu_pkg::if_id_t in,
    fwd_if.sink             fwd,         // wb port drives register writes
    output cpu_pkg::id_ex_t out,
    output logic            redirect,    // j or taken branch
    output cpu_pkg::word_t  redirect_pc,
    output logic            is_branch    // for hazard unit
);

    cpu_pkg::word_t    regs [32];
    cpu_pkg::reg_idx_t rs, rt, rd;
    cpu_pkg::word_t    rs_val, rt_val;
    cpu_pkg::word_t    imm_ext;
    cpu_pkg::word_t    branch_target, jump_target;
    logic              is_jump, taken;

    assign rs      = in.instr[25:21];
    assign rt      = in.instr[20:16];
    assign rd      = in.instr[15:11];
    assign imm_ext = {{16{in.instr[15]}}, in.instr[15:0]};

    // register file
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (fwd.wb_we) begin
            regs[fwd.wb_dst] <= fwd.wb_result;
        end
    end

    // r0 reads zero, same-cycle wb write bypassed
    assign rs_val = (rs == '0) ? '0 :
                    (fwd.wb_we && fwd.wb_dst == rs) ? fwd.wb_result : regs[rs];
    assign rt_val = (rt == '0) ? '0 :
                    (fwd.wb_we && fwd.wb_dst == rt) ? fwd.wb_result : regs[rt];

    assign branch_target = in.pc_plus4 + {imm_ext[29:0], 2'b00};
    assign jump_target   = {in.pc_plus4[31:28], in.instr[25:0], 2'b00};

    always_comb begin
        out       = '0;                  // bubble unless valid
        is_branch = 1'b0;
        is_jump   = 1'b0;
        taken     = 1'b0;
        if (in.valid) begin
            out.valid      = 1'b1;
            out.op1        = rs_val;
            out.op2        = rt_val;
            out.store_data = rt_val;
            out.src1       = rs;
            case (cpu_pkg::opcode_t'(in.instr[31:26]))
                cpu_pkg::OP_RTYPE: begin
                    out.src2      = rt;
                    out.dst       = rd;
                    out.reg_write = 1'b1;
                    case (cpu_pkg::funct_t'(in.instr[5:0]))
                        cpu_pkg::F_ADD: out.alu_op = cpu_pkg::ALU_ADD;
                        cpu_pkg::F_SUB: out.alu_op = cpu_pkg::ALU_SUB;
                        cpu_pkg::F_AND: out.alu_op = cpu_pkg::ALU_AND;
                        cpu_pkg::F_OR:  out.alu_op = cpu_pkg::ALU_OR;
                        cpu_pkg::F_SLT: out.alu_op = cpu_pkg::ALU_SLT;
                        default:        out.reg_write = 1'b0;   // unknown funct acts as nop
                    endcase
                end
                cpu_pkg::OP_ADDI: begin
                    out.op2       = imm_ext;
                    out.dst       = rt;
                    out.reg_write = 1'b1;
                end
                cpu_pkg::OP_LW: begin
                    out.op2       = imm_ext;
                    out.dst       = rt;
                    out.reg_write = 1'b1;
                    out.mem_read  = 1'b1;
                end
                cpu_pkg::OP_SW: begin
                    out.op2       = imm_ext;   // address offset
                    out.src2      = rt;        // store data source
                    out.mem_write = 1'b1;
                end
                cpu_pkg::OP_BEQ: begin
                    out.src2  = rt;
                    is_branch = 1'b1;
                    taken     = (rs_val == rt_val);
                end
                cpu_pkg::OP_BNE: begin
                    out.src2  = rt;
                    is_branch = 1'b1;
                    taken     = (rs_val != rt_val);
                end
                cpu_pkg::OP_J: begin
                    out.src1 = '0;
                    is_jump  = 1'b1;
                end
                default: begin           // unused word, travels as a harmless nop
                    out.op1        = '0;
                    out.op2        = '0;
                    out.store_data = '0;
                    out.src1       = '0;
                end
            endcase
            if (out.dst == '0) out.reg_write = 1'b0;   // writes to r0 dropped here
        end
    end

    assign redirect    = is_jump || (is_branch && taken);
    assign redirect_pc = is_jump ? jump_target : branch_target;

    // r0 filtering above must hold all the way to write-back
    a_no_r0_write : assert property (@(posedge clk) disable iff (!rst_n)
        fwd.wb_we |-> fwd.wb_dst != '0)
        else $error("decode_unit: write to r0 reached write-back");

endmodule

`default_nettype wire

/* src/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  cpu_pkg::id_ex_t  in,
    fwd_if.sink              fwd,
    output cpu_pkg::ex_mem_t out
);

    cpu_pkg::fwd_sel_t sel1, sel2;
    cpu_pkg::word_t    a, b, st_data;

    // newest nonzero writer wins, mem before wb
    function automatic cpu_pkg::fwd_sel_t pick(input cpu_pkg::reg_idx_t idx);
        if (idx == '0) return cpu_pkg::FWD_REG;
        if (fwd.mem_we && fwd.mem_dst == idx) return cpu_pkg::FWD_MEM;
        if (fwd.wb_we && fwd.wb_dst == idx) return cpu_pkg::FWD_WB;
        return cpu_pkg::FWD_REG;
    endfunction

    function automatic cpu_pkg::word_t mux(input cpu_pkg::fwd_sel_t s,
                                           input cpu_pkg::word_t reg_val);
        case (s)
            cpu_pkg::FWD_MEM: return fwd.mem_result;
            cpu_pkg::FWD_WB:  return fwd.wb_result;
            default:          return reg_val;
        endcase
    endfunction

    always_comb begin
        sel1    = pick(in.src1);
        sel2    = pick(in.src2);
        a       = mux(sel1, in.op1);
        b       = in.mem_write ? in.op2 : mux(sel2, in.op2);   // sw: op2 is the offset
        st_data = mux(sel2, in.store_data);
    end

    always_comb begin
        out            = '0;
        out.valid      = in.valid;
        out.store_data = st_data;
        out.dst        = in.dst;
        out.reg_write  = in.reg_write;
        out.mem_read   = in.mem_read;
        out.mem_write  = in.mem_write;
        case (in.alu_op)
            cpu_pkg::ALU_SUB: out.result = a - b;
            cpu_pkg::ALU_AND: out.result = a & b;
            cpu_pkg::ALU_OR:  out.result = a | b;
            cpu_pkg::ALU_SLT: out.result = {31'd0, $signed(a) < $signed(b)};
            default:          out.result = a + b;   // add, addresses
        endcase
    end

    // load-use stall keeps load data off the mem forwarding path
    a_no_load_fwd : assert property (@(posedge fwd.clk) disable iff (!fwd.rst_n)
        in.valid && (sel1 == cpu_pkg::FWD_MEM || sel2 == cpu_pkg::FWD_MEM) |-> !fwd.mem_rd)
        else $error("execute_unit: forwarding from a load in mem");

endmodule

`default_nettype wire

/* src/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    input  logic              imem_we,       // loader strobe
    input  cpu_pkg::word_t    imem_addr,     // byte address, word aligned
    input  cpu_pkg::word_t    imem_wdata,
    input  logic              stall,
    input  logic              redirect,      // from decode
    input  cpu_pkg::word_t    redirect_pc,
    output cpu_pkg::if_id_t   fetched
);

    localparam int AW = $clog2(IMEM_DEPTH);

    cpu_pkg::word_t imem [IMEM_DEPTH];
    cpu_pkg::word_t pc;

    always_ff @(posedge clk) begin
        if (imem_we) imem[imem_addr[AW + 1:2]] <= imem_wdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;                    // parked while loading
        end else if (!stall) begin
            pc <= redirect ? redirect_pc : pc + 32'd4;
        end
    end

    assign fetched.valid    = run;
    assign fetched.instr    = imem[pc[AW + 1:2]];   // async read
    assign fetched.pc_plus4 = pc + 32'd4;

    a_load_idle : assert property (@(posedge clk) disable iff (!rst_n) run |-> !imem_we)
        else $error("fetch_unit: imem write while running");

endmodule

`default_nettype wire

/* src/fwd_if.sv */
`timescale 1ns/1ps
`default_nettype none

// results of mem and wb stages, seen by forwarding, hazard and register file
interface fwd_if (
    input logic clk,
    input logic rst_n
);
    cpu_pkg::reg_idx_t mem_dst;
    logic              mem_we;           // valid and writing a register
    logic              mem_rd;           // valid load
    cpu_pkg::word_t    mem_result;       // alu result, never load data

    cpu_pkg::reg_idx_t wb_dst;
    logic              wb_we;
    cpu_pkg::word_t    wb_result;

    modport mem_src (output mem_dst, mem_we, mem_rd, mem_result);
    modport wb_src  (output wb_dst, wb_we, wb_result);
    modport sink    (input clk, rst_n, mem_dst, mem_we, mem_rd, mem_result,
                     wb_dst, wb_we, wb_result);
endinterface

`default_nettype wire

/* src/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  cpu_pkg::reg_idx_t id_src1,
    input  cpu_pkg::reg_idx_t id_src2,
    input  logic              is_branch,
    input  cpu_pkg::id_ex_t   ex_stage,
    fwd_if.sink               fwd,
    input  logic              redirect,
    input  logic              run,
    output logic              stall_front,   // hold pc and if/id
    output logic              flush_if_id,
    output logic              flush_id_ex
);

    logic ex_load, ex_write;
    logic load_use, branch_wait;

    assign ex_load  = ex_stage.valid && ex_stage.mem_read && ex_stage.dst != '0;
    assign ex_write = ex_stage.valid && ex_stage.reg_write;     // dst nonzero by decode

    assign load_use = ex_load && (ex_stage.dst == id_src1 || ex_stage.dst == id_src2);

    // branch compares in decode, so ex and mem producers must drain first
    assign branch_wait = is_branch &&
        ((ex_write && (ex_stage.dst == id_src1 || ex_stage.dst == id_src2)) ||
         (fwd.mem_we && (fwd.mem_dst == id_src1 || fwd.mem_dst == id_src2)));

    assign stall_front = load_use || branch_wait;
    assign flush_id_ex = stall_front || !run;                   // bubble behind the stall
    assign flush_if_id = (redirect && !stall_front) || !run;    // squash the fetched slot

endmodule

`default_nettype wire

/* src/memory_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_unit #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::ex_mem_t in,
    output cpu_pkg::mem_wb_t out,
    fwd_if.mem_src           fwd
);

    localparam int AW = $clog2(DMEM_DEPTH);

    cpu_pkg::word_t dmem [DMEM_DEPTH];   // word addressed
    cpu_pkg::word_t rd_data;

    assign rd_data = dmem[in.result[AW + 1:2]];

    always_ff @(posedge clk) begin
        if (in.valid && in.mem_write) dmem[in.result[AW + 1:2]] <= in.store_data;
    end

    assign out.valid     = in.valid;
    assign out.dst       = in.dst;
    assign out.reg_write = in.reg_write;
    assign out.result    = in.mem_read ? rd_data : in.result;   // wb select lives here

    assign fwd.mem_dst    = in.dst;
    assign fwd.mem_we     = in.valid && in.reg_write;
    assign fwd.mem_rd     = in.valid && in.mem_read;
    assign fwd.mem_result = in.result;

    a_addr_ok : assert property (@(posedge clk) disable iff (!rst_n)
        in.valid && (in.mem_read || in.mem_write) |->
        in.result[1:0] == 2'b00 && in.result < DMEM_DEPTH * 4)
        else $error("memory_unit: misaligned or out of range access");

endmodule

`default_nettype wire

/* src/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,              // hold content
    input  logic     flush,              // insert bubble, beats stall
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;                     // valid cleared with the rest
        end else if (!stall) begin
            q <= d;
        end
    end

    // upstream stages must never hand over unknown payload bits
    a_q_known : assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(q))
        else $error("pipe_reg: unknown payload");

endmodule

`default_nettype wire

/* tests/tb_cpu_model.svh */
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

// r type word, shamt always 0
function automatic void emit_r(cpu_pkg::funct_t f, int rd, int rs, int rt);
    prog.push_back({6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, f});
endfunction

function automatic void emit_i(cpu_pkg::opcode_t op, int rt, int rs, int imm);
    prog.push_back({op, 5'(rs), 5'(rt), 16'(imm)});
endfunction

function automatic void emit_j(int target);     // byte address
    prog.push_back({cpu_pkg::OP_J, 26'(target >> 2)});
endfunction

// jump to self parks the core, nop covers the fetch slot behind it
function automatic void emit_halt();
    emit_j(prog.size() * 4);
    prog.push_back('0);
endfunction

function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
endfunction

// presets r1..r7 and data words 0..7, then a random body with forward branches only
function automatic void build_random(int body_len);
    cpu_pkg::funct_t  functs [5] = '{cpu_pkg::F_ADD, cpu_pkg::F_SUB, cpu_pkg::F_AND,
                                     cpu_pkg::F_OR, cpu_pkg::F_SLT};
    cpu_pkg::opcode_t br_ops [2] = '{cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE};
    int rem;
    int off;
    prog.delete();
    for (int r = 1; r < 8; r++)
        emit_i(cpu_pkg::OP_ADDI, r, 0, rand_below(65536));
    for (int k = 0; k < 8; k++)
        emit_i(cpu_pkg::OP_SW, 1 + k % 7, 0, k * 4);   // every later load hits a stored word
    for (int i = 0; i < body_len; i++) begin
        rem = body_len - 1 - i;                    // words left before the halt
        case (rand_below(8))
            0, 1, 2, 3: emit_r(functs[rand_below(5)], rand_below(16), rand_below(16),
                               rand_below(16));
            4: emit_i(cpu_pkg::OP_ADDI, rand_below(16), rand_below(16), rand_below(65536));
            5: emit_i(cpu_pkg::OP_LW, rand_below(16), 0, rand_below(8) * 4);
            6: emit_i(cpu_pkg::OP_SW, rand_below(16), 0, rand_below(8) * 4);
            default: begin
                off = (rem == 0) ? 0 : 1 + rand_below(rem < 3 ? rem : 3);
                emit_i(br_ops[rand_below(2)], rand_below(16), rand_below(16), off);
            end
        endcase
    end
    emit_halt();
endfunction

// architectural reference, runs prog from address 0 up to the halt jump
function automatic void run_model();
    cpu_pkg::word_t    regs [32];
    cpu_pkg::word_t    mem [256];
    cpu_pkg::word_t    pc, ins, a, b, imm, res, jt;
    cpu_pkg::reg_idx_t dst;
    bit                halted;
    int                steps;
    foreach (regs[i]) regs[i] = '0;
    foreach (mem[i]) mem[i] = '0;
    pc     = '0;
    res    = '0;
    halted = 1'b0;
    steps  = 0;
    while (!halted && steps < 4096) begin
        ins = prog[pc >> 2];
        a   = regs[ins[25:21]];
        b   = regs[ins[20:16]];
        imm = {{16{ins[15]}}, ins[15:0]};
        dst = '0;                                  // no write unless set below
        pc  = pc + 4;                              // no delay slot
        case (ins[31:26])
            cpu_pkg::OP_RTYPE: begin
                dst = ins[15:11];
                case (ins[5:0])
                    cpu_pkg::F_ADD: res = a + b;
                    cpu_pkg::F_SUB: res = a - b;
                    cpu_pkg::F_AND: res = a & b;
                    cpu_pkg::F_OR:  res = a | b;
                    cpu_pkg::F_SLT: res = ($signed(a) < $signed(b)) ? 1 : 0;
                    default:        dst = '0;
                endcase
            end
            cpu_pkg::OP_ADDI: begin
                dst = ins[20:16];
                res = a + imm;
            end
            cpu_pkg::OP_LW: begin
                dst = ins[20:16];
                res = mem[(a + imm) >> 2];
            end
            cpu_pkg::OP_SW:  mem[(a + imm) >> 2] = b;
            cpu_pkg::OP_BEQ: if (a == b) pc = pc + (imm << 2);
            cpu_pkg::OP_BNE: if (a != b) pc = pc + (imm << 2);
            cpu_pkg::OP_J: begin
                jt     = {pc[31:28], ins[25:0], 2'b00};
                halted = (jt == pc - 4);
                pc     = jt;
            end
            default: ;
        endcase
        if (dst != '0) begin                       // r0 never retires
            regs[dst] = res;
            exp_reg.push_back(dst);
            exp_val.push_back(res);
        end
        steps++;
    end
endfunction

`endif

/* tests/tb_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

    logic              clk;
    logic              rst_n;
    logic              run;
    logic              imem_we;
    cpu_pkg::word_t    imem_addr;
    cpu_pkg::word_t    imem_wdata;
    logic              retire_valid;
    cpu_pkg::reg_idx_t retire_reg;
    cpu_pkg::word_t    retire_data;

    cpu_pkg::word_t    prog [$];             // program under test
    cpu_pkg::reg_idx_t exp_reg [$];          // expected retirements, oldest first
    cpu_pkg::word_t    exp_val [$];
    integer            seed = 49624;
    int                budget_cycles = 100;  // grows by 40 per loaded word
    int                retired;

    `include "tb_cpu_model.svh"

    cpu_top #(.IMEM_DEPTH(256), .DMEM_DEPTH(256)) cpu_top_i (
        .clk(clk), .rst_n(rst_n), .run(run), .imem_we(imem_we), .imem_addr(imem_addr),
        .imem_wdata(imem_wdata), .retire_valid(retire_valid), .retire_reg(retire_reg),
        .retire_data(retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;               // 4 ns period
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_retire(input cpu_pkg::reg_idx_t got_reg, input cpu_pkg::word_t got_val);
        cpu_pkg::reg_idx_t want_reg;
        cpu_pkg::word_t    want_val;
        if (exp_reg.size() == 0) begin
            $display("ERR %0t: unexpected retirement r%0d = %h", $time, got_reg, got_val);
            abort_run();
        end else begin
            want_reg = exp_reg.pop_front();
            want_val = exp_val.pop_front();
            retired++;
            if (got_reg !== want_reg || got_val !== want_val) begin
                $display("ERR %0t: retirement %0d expected r%0d = %h, got r%0d = %h",
                         $time, retired, want_reg, want_val, got_reg, got_val);
                abort_run();
            end
        end
    endtask

    // retire outputs change on the rising edge, sampled on the falling one
    initial begin
        forever begin
            @(negedge clk);
            if (retire_valid === 1'b1)
                check_retire(retire_reg, retire_data);
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > budget_cycles) begin
                $display("watchdog expired at %0t: core stopped retiring", $time);
                abort_run();
            end
        end
    end

    // reset, load prog with run low, fill the expected queue, run until it drains
    task automatic run_program(input string name);
        retired = 0;
        budget_cycles += 40 * prog.size();
        run   = 1'b0;
        rst_n = 1'b0;                        // register file back to zero
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (prog[i]) begin
            imem_we    = 1'b1;               // one strobe per word
            imem_addr  = i * 4;
            imem_wdata = prog[i];
            @(posedge clk);
            #1;
        end
        imem_we = 1'b0;
        exp_reg.delete();
        exp_val.delete();
        run_model();
        $display("%s: %0d words, %0d retirements expected", name, prog.size(), exp_reg.size());
        run = 1'b1;
        while (exp_reg.size() != 0)
            @(posedge clk);
        repeat (8) @(posedge clk);           // stray retirements behind the halt
        #1;
        run = 1'b0;
    endtask

    initial begin
        rst_n      = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        @(posedge clk);
        #1;

        prog.delete();                       // independent ops first, then a forwarding chain
        emit_i(cpu_pkg::OP_ADDI, 1, 0, 5);
        emit_i(cpu_pkg::OP_ADDI, 2, 0, -3);
        emit_i(cpu_pkg::OP_ADDI, 3, 0, 16'h7abc);
        emit_i(cpu_pkg::OP_ADDI, 4, 0, 16'h0f0f);
        emit_i(cpu_pkg::OP_ADDI, 0, 0, 9);   // dropped write
        emit_i(cpu_pkg::OP_ADDI, 9, 0, 1);
        emit_r(cpu_pkg::F_SUB, 5, 1, 2);
        emit_r(cpu_pkg::F_AND, 6, 3, 4);
        emit_r(cpu_pkg::F_OR, 7, 1, 3);
        emit_r(cpu_pkg::F_SLT, 8, 2, 1);
        emit_i(cpu_pkg::OP_ADDI, 12, 0, 10);
        emit_r(cpu_pkg::F_ADD, 13, 12, 12);  // from mem
        emit_r(cpu_pkg::F_SUB, 14, 13, 12);  // mem and wb
        emit_r(cpu_pkg::F_SLT, 15, 12, 14);
        emit_r(cpu_pkg::F_OR, 16, 15, 13);
        emit_halt();
        run_program("alu and forwarding");

        prog.delete();
        emit_i(cpu_pkg::OP_ADDI, 1, 0, 64);
        emit_i(cpu_pkg::OP_ADDI, 2, 0, 77);
        emit_i(cpu_pkg::OP_ADDI, 3, 0, -1);
        emit_i(cpu_pkg::OP_SW, 2, 1, 0);
        emit_i(cpu_pkg::OP_SW, 3, 1, 8);
        emit_i(cpu_pkg::OP_LW, 4, 1, 0);
        emit_r(cpu_pkg::F_ADD, 5, 4, 2);     // load-use
        emit_i(cpu_pkg::OP_LW, 6, 1, 8);
        emit_i(cpu_pkg::OP_SW, 6, 1, 4);     // store of fresh load data
        emit_i(cpu_pkg::OP_LW, 7, 1, 4);
        emit_i(cpu_pkg::OP_SW, 5, 1, 0);     // overwrite, reload same word
        emit_i(cpu_pkg::OP_LW, 8, 1, 0);
        emit_i(cpu_pkg::OP_LW, 9, 1, 8);
        emit_halt();
        run_program("load and store");

        prog.delete();
        emit_i(cpu_pkg::OP_ADDI, 1, 0, 3);
        emit_i(cpu_pkg::OP_ADDI, 2, 0, 3);
        emit_i(cpu_pkg::OP_BEQ, 2, 1, 1);    // needs r2 from the word before, taken
        emit_i(cpu_pkg::OP_ADDI, 3, 0, 99);  // squashed
        emit_i(cpu_pkg::OP_BNE, 2, 1, 5);    // not taken
        emit_i(cpu_pkg::OP_ADDI, 4, 1, 1);
        emit_i(cpu_pkg::OP_BNE, 4, 1, 2);    // taken over two words
        emit_i(cpu_pkg::OP_ADDI, 5, 0, 55);
        emit_i(cpu_pkg::OP_ADDI, 6, 0, 66);
        emit_j((prog.size() + 2) * 4);
        emit_i(cpu_pkg::OP_ADDI, 7, 0, 77);  // skipped by j
        emit_i(cpu_pkg::OP_SW, 4, 0, 0);
        emit_i(cpu_pkg::OP_LW, 8, 0, 0);
        emit_i(cpu_pkg::OP_BEQ, 8, 4, 1);    // waits for the load
        emit_i(cpu_pkg::OP_ADDI, 9, 0, 99);
        emit_i(cpu_pkg::OP_ADDI, 10, 0, 10);
        emit_halt();
        run_program("branches and jump");

        for (int n = 0; n < 20; n++) begin
            build_random(24);
            run_program($sformatf("random %0d", n));
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
